// File: src.f
common/mmio_tlp_pkg.sv
source/meta_ram.sv
source/fifo2.sv
mmio_tlp/mmio_tlp_gen.sv
source/mmio_reg_sink.sv
source/mmio_host_chan.sv
tb/mmio_host_chan_tb.sv

// File: Bender.yml
package:
  name: mmio_host_chan

sources:
  - files:
      - common/mmio_tlp_pkg.sv
      - source/meta_ram.sv
      - source/fifo2.sv
      - mmio_tlp/mmio_tlp_gen.sv
      - source/mmio_reg_sink.sv
      - source/mmio_host_chan.sv

  - target: simulation
    files:
      - tb/mmio_host_chan_tb.sv

// File: tb/mmio_host_chan_tb.sv
/*
 * Testbench for the PCIe host channel MMIO path
 * Random memory TLPs against a register model, completions checked in read order
 */

`timescale 1ns/100ps

module mmio_host_chan_tb;

    localparam int n_tags = 64;
    localparam int n_regs = 16;
    localparam int n_tlps = 400;
    localparam int cycle_limit = n_tlps * 40;
    localparam int drain_cycles = 20;

    logic clk;
    logic reset_n;
    logic rx_valid;
    logic rx_ready;
    mmio_tlp_pkg::pcie_hdr_u rx_hdr;
    logic rx_sop;
    logic rx_poison;
    logic [mmio_tlp_pkg::data_w-1:0] rx_data;
    logic tx_valid;
    logic tx_ready;
    mmio_tlp_pkg::pcie_hdr_u tx_hdr;
    logic [mmio_tlp_pkg::data_w-1:0] tx_data;
    logic [7:0] tx_keep;

    // Register model, expected completions and free read tags
    logic [mmio_tlp_pkg::data_w-1:0] model_regs [n_regs];
    mmio_tlp_pkg::pcie_hdr_u exp_hdr_q [$];
    logic [mmio_tlp_pkg::data_w-1:0] exp_data_q [$];
    logic [7:0] exp_keep_q [$];
    int exp_tag_q [$];
    int free_tags [$];

    int cycles = 0;
    int reads_sent;
    int n_checked;

    mmio_host_chan
    #(
        .n_tags(n_tags),
        .n_regs(n_regs)
    )
    u_mmio_host_chan
    (
        .clk(clk),
        .reset_n(reset_n),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .rx_hdr(rx_hdr),
        .rx_sop(rx_sop),
        .rx_poison(rx_poison),
        .rx_data(rx_data),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .tx_hdr(tx_hdr),
        .tx_data(tx_data),
        .tx_keep(tx_keep)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("ERROR: the test did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_hdr(input mmio_tlp_pkg::pcie_hdr_u got,
                             input mmio_tlp_pkg::pcie_hdr_u exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s header got %h expected %h",
                     $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_data(input logic [mmio_tlp_pkg::data_w-1:0] got,
                              input logic [mmio_tlp_pkg::data_w-1:0] exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s data got %h expected %h",
                     $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_keep(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s keep got %h expected %h",
                     $time, what, got, exp);
            abort_run();
        end
    endtask

    // Completion header expected for a read request
    function automatic mmio_tlp_pkg::pcie_hdr_u expected_cpl(mmio_tlp_pkg::pcie_hdr_u req);
        mmio_tlp_pkg::pcie_hdr_u c;
        logic [11:0] bc;
        bc = (req.mem_req.length == 10'd2) ? 12'd8 : 12'd4;
        c = '0;
        c.cpl.fmttype = mmio_tlp_pkg::fmttype_cpld;
        c.cpl.length = 10'(bc / 4);
        c.cpl.vchan = req.mem_req.vchan;
        c.cpl.tag = req.mem_req.tag;
        c.cpl.requester_id = req.mem_req.requester_id;
        c.cpl.tc = req.mem_req.tc;
        c.cpl.byte_count = bc;
        c.cpl.lower_addr = req.mem_req.addr[6:0];
        return c;
    endfunction

    // Builds the next RX beat and applies it to the model
    task automatic drive_tlp(input int n);
        int kind;
        int roll;
        int idx;
        logic wide;
        logic half;
        logic [7:0] tag;
        logic [7:0] fmttype;
        logic [mmio_tlp_pkg::data_w-1:0] data;
        mmio_tlp_pkg::pcie_hdr_u hdr;

        // First pass reads every register straight after reset
        if (n < n_regs)
        begin
            kind = 1;
            idx = n;
            wide = 1'b1;
        end
        else
        begin
            roll = $urandom_range(0, 99);
            if (roll < 35)
                kind = 0;
            else if (roll < 75)
                kind = 1;
            else if (roll < 83)
                kind = 2;
            else if (roll < 91)
                kind = 3;
            else
                kind = 4;
            idx = $urandom_range(0, n_regs - 1);
            wide = 1'($urandom_range(0, 1));
        end
        if (kind == 1 && free_tags.size() == 0)
        begin
            kind = 0;
        end
        half = wide ? 1'b0 : 1'($urandom_range(0, 1));
        data = {$urandom(), $urandom()};

        if (kind == 0)
            fmttype = mmio_tlp_pkg::fmttype_mwr;
        else if (kind == 1)
            fmttype = mmio_tlp_pkg::fmttype_mrd;
        else if (kind == 4)
        begin
            // Any code that is neither a memory read nor a memory write
            fmttype = 8'($urandom());
            while (fmttype == mmio_tlp_pkg::fmttype_mrd || fmttype == mmio_tlp_pkg::fmttype_mwr)
            begin
                fmttype = 8'($urandom());
            end
        end
        else
            fmttype = $urandom_range(0, 1) ? mmio_tlp_pkg::fmttype_mwr : mmio_tlp_pkg::fmttype_mrd;

        tag = (kind == 1) ? 8'(free_tags.pop_front()) : 8'($urandom());

        hdr = '0;
        hdr.mem_req.fmttype = fmttype;
        hdr.mem_req.length = wide ? 10'd2 : 10'd1;
        hdr.mem_req.vchan = 2'($urandom_range(0, 3));
        hdr.mem_req.tag = tag;
        hdr.mem_req.requester_id = 16'($urandom());
        hdr.mem_req.tc = 3'($urandom_range(0, 7));
        hdr.mem_req.addr = {25'($urandom()), 4'(idx), half, 2'b00};

        rx_hdr = hdr;
        rx_data = data;
        rx_sop = (kind != 3);
        rx_poison = (kind == 2);
        rx_valid = 1'b1;

        if (kind == 0)
        begin
            if (wide)
                model_regs[idx] = data;
            else if (half)
                model_regs[idx][63:32] = data[31:0];
            else
                model_regs[idx][31:0] = data[31:0];
        end
        else if (kind == 1)
        begin
            exp_hdr_q.push_back(expected_cpl(hdr));
            if (wide)
                exp_data_q.push_back(model_regs[idx]);
            else if (half)
                exp_data_q.push_back({32'h0, model_regs[idx][63:32]});
            else
                exp_data_q.push_back({32'h0, model_regs[idx][31:0]});
            exp_keep_q.push_back(wide ? 8'hff : 8'h0f);
            exp_tag_q.push_back(int'(tag));
            reads_sent++;
        end
    endtask

    // Completion accepted at the coming edge
    task automatic check_completion();
        string what;
        if (exp_hdr_q.size() == 0)
        begin
            $display("ERROR: completion at %0t ns without an outstanding read", $time);
            abort_run();
        end
        else
        begin
            what = $sformatf("completion for tag %0d", exp_tag_q[0]);
            check_hdr(tx_hdr, exp_hdr_q[0], what);
            check_data(tx_data, exp_data_q[0], what);
            check_keep(tx_keep, exp_keep_q[0], what);
            void'(exp_hdr_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_keep_q.pop_front());
            free_tags.push_back(exp_tag_q.pop_front());
            n_checked++;
        end
    endtask

    initial
    begin
        int sent;
        logic taken;

        void'($urandom(47));
        $timeformat(-9, 0, "", 1);
        reset_n = 1'b0;
        rx_valid = 1'b0;
        rx_hdr = '0;
        rx_sop = 1'b0;
        rx_poison = 1'b0;
        rx_data = '0;
        tx_ready = 1'b0;
        reads_sent = 0;
        n_checked = 0;
        sent = 0;
        taken = 1'b0;
        for (int i = 0; i < n_regs; i++)
        begin
            model_regs[i] = '0;
        end
        for (int t = 0; t < n_tags; t++)
        begin
            free_tags.push_back(t);
        end

        repeat (10) @(negedge clk);
        reset_n = 1'b1;

        while (sent < n_tlps || exp_hdr_q.size() != 0)
        begin
            @(negedge clk);
            if (taken)
            begin
                rx_valid = 1'b0;
                sent++;
            end

            // Nothing may leave before the first read goes out
            if (reads_sent == 0 && tx_valid)
            begin
                $display("ERROR: tx_valid high at %0t ns before any read was sent", $time);
                abort_run();
            end

            tx_ready = ($urandom_range(0, 99) < 70);
            if (tx_valid && tx_ready)
            begin
                check_completion();
            end

            if (!rx_valid && sent < n_tlps && $urandom_range(0, 99) < 85)
            begin
                drive_tlp(sent);
            end
            // rx_ready only depends on registers, so it holds until the edge
            taken = rx_valid && rx_ready;
        end

        // Any further completion would be a duplicate
        repeat (drain_cycles)
        begin
            @(negedge clk);
            tx_ready = 1'b1;
            if (tx_valid)
            begin
                $display("ERROR: extra completion at %0t ns after all reads were answered",
                         $time);
                abort_run();
            end
        end

        $display("%0d TLPs sent, %0d completions checked", sent, n_checked);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: source/mmio_host_chan.sv
/*
 * PCIe host channel MMIO path
 * TLP engine joined to the AFU register file
 */

`timescale 1ns/100ps

module mmio_host_chan
#(
    parameter int n_tags = 64,
    parameter int n_regs = 16
)
(
    input  logic clk,
    input  logic reset_n,

    input  logic rx_valid,
    output logic rx_ready,
    input  mmio_tlp_pkg::pcie_hdr_u rx_hdr,
    input  logic rx_sop,
    input  logic rx_poison,
    input  logic [mmio_tlp_pkg::data_w-1:0] rx_data,

    output logic tx_valid,
    input  logic tx_ready,
    output mmio_tlp_pkg::pcie_hdr_u tx_hdr,
    output logic [mmio_tlp_pkg::data_w-1:0] tx_data,
    output logic [7:0] tx_keep
);

    logic req_valid;
    logic req_ready;
    logic [mmio_tlp_pkg::mmio_tag_w-1:0] req_tag;
    logic [31:0] req_addr;
    logic [11:0] req_byte_count;
    logic req_is_write;
    logic [mmio_tlp_pkg::data_w-1:0] req_payload;

    logic rsp_valid;
    logic rsp_ready;
    logic [mmio_tlp_pkg::mmio_tag_w-1:0] rsp_tag;
    logic [mmio_tlp_pkg::data_w-1:0] rsp_payload;

    mmio_tlp_gen
    #(
        .n_tags(n_tags)
    )
    u_mmio_tlp_gen
    (
        .clk(clk),
        .reset_n(reset_n),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .rx_hdr(rx_hdr),
        .rx_sop(rx_sop),
        .rx_poison(rx_poison),
        .rx_data(rx_data),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_tag(req_tag),
        .req_addr(req_addr),
        .req_byte_count(req_byte_count),
        .req_is_write(req_is_write),
        .req_payload(req_payload),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_tag(rsp_tag),
        .rsp_payload(rsp_payload),
        .tx_valid(tx_valid),
        .tx_ready(tx_ready),
        .tx_hdr(tx_hdr),
        .tx_data(tx_data),
        .tx_keep(tx_keep)
    );

    mmio_reg_sink
    #(
        .n_regs(n_regs)
    )
    u_mmio_reg_sink
    (
        .clk(clk),
        .reset_n(reset_n),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_tag(req_tag),
        .req_addr(req_addr),
        .req_byte_count(req_byte_count),
        .req_is_write(req_is_write),
        .req_payload(req_payload),
        .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready),
        .rsp_tag(rsp_tag),
        .rsp_payload(rsp_payload)
    );

endmodule

// File: source/mmio_reg_sink.sv
/*
 * AFU register file
 * 64-bit registers written and read over the MMIO request stream,
 * read data returned one cycle after acceptance
 */

`timescale 1ns/100ps

module mmio_reg_sink
#(
    parameter int n_regs = 16
)
(
    input  logic clk,
    input  logic reset_n,

    input  logic req_valid,
    output logic req_ready,
    input  logic [mmio_tlp_pkg::mmio_tag_w-1:0] req_tag,
    input  logic [31:0] req_addr,
    input  logic [11:0] req_byte_count,
    input  logic req_is_write,
    input  logic [mmio_tlp_pkg::data_w-1:0] req_payload,

    output logic rsp_valid,
    input  logic rsp_ready,
    output logic [mmio_tlp_pkg::mmio_tag_w-1:0] rsp_tag,
    output logic [mmio_tlp_pkg::data_w-1:0] rsp_payload
);

    localparam int idx_w = $clog2(n_regs);

    logic [mmio_tlp_pkg::data_w-1:0] regs [n_regs];
    logic [idx_w-1:0] idx;
    logic full_word;
    logic wr_accept;
    logic rd_accept;
    logic [mmio_tlp_pkg::data_w-1:0] rd_word;

    // Register index starts above the byte offset within a 64-bit word
    assign idx = req_addr[idx_w+2:3];
    assign full_word = (req_byte_count == 12'd8);

    // Only one read in flight, so stall while a response is stuck
    assign req_ready = !rsp_valid || rsp_ready;
    assign wr_accept = req_valid && req_ready && req_is_write;
    assign rd_accept = req_valid && req_ready && !req_is_write;

    always_comb
    begin
        if (full_word)
        begin
            rd_word = regs[idx];
        end
        else if (req_addr[2])
        begin
            rd_word = {32'h0, regs[idx][63:32]};
        end
        else
        begin
            rd_word = {32'h0, regs[idx][31:0]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < n_regs; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_accept)
        begin
            if (full_word)
            begin
                regs[idx] <= req_payload;
            end
            else if (req_addr[2])
            begin
                regs[idx][63:32] <= req_payload[31:0];
            end
            else
            begin
                regs[idx][31:0] <= req_payload[31:0];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_valid <= 1'b0;
        end
        else if (rd_accept)
        begin
            rsp_valid <= 1'b1;
        end
        else if (rsp_ready)
        begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_accept)
        begin
            rsp_tag <= req_tag;
            rsp_payload <= rd_word;
        end
    end

endmodule

// File: mmio_tlp/mmio_tlp_gen.sv
/*
 * MMIO TLP engine
 * Turns host memory TLPs into MMIO requests, keeps per-tag read metadata
 * and builds completion-with-data TLPs from the register file responses
 */

`timescale 1ns/100ps

module mmio_tlp_gen
#(
    parameter int n_tags = 64
)
(
    input  logic clk,
    input  logic reset_n,

    // Host RX stream
    input  logic rx_valid,
    output logic rx_ready,
    input  mmio_tlp_pkg::pcie_hdr_u rx_hdr,
    input  logic rx_sop,
    input  logic rx_poison,
    input  logic [mmio_tlp_pkg::data_w-1:0] rx_data,

    // MMIO requests toward the register file
    output logic req_valid,
    input  logic req_ready,
    output logic [mmio_tlp_pkg::mmio_tag_w-1:0] req_tag,
    output logic [31:0] req_addr,
    output logic [11:0] req_byte_count,
    output logic req_is_write,
    output logic [mmio_tlp_pkg::data_w-1:0] req_payload,

    // Read responses from the register file
    input  logic rsp_valid,
    output logic rsp_ready,
    input  logic [mmio_tlp_pkg::mmio_tag_w-1:0] rsp_tag,
    input  logic [mmio_tlp_pkg::data_w-1:0] rsp_payload,

    // Host TX completions
    output logic tx_valid,
    input  logic tx_ready,
    output mmio_tlp_pkg::pcie_hdr_u tx_hdr,
    output logic [mmio_tlp_pkg::data_w-1:0] tx_data,
    output logic [7:0] tx_keep
);

    localparam int tag_idx_w = $clog2(n_tags);
    // tag, vchan, lower address, byte count, requester ID, tc
    localparam int meta_w = mmio_tlp_pkg::mmio_tag_w + 2 + 7 + 12 + 16 + 3;

    logic rd_accept;
    logic rsp_hs;
    logic [tag_idx_w-1:0] rd_idx;
    logic [tag_idx_w-1:0] rsp_idx;
    logic [meta_w-1:0] rd_meta;
    logic [meta_w-1:0] ram_rdata;
    logic rsp_hs_q;
    logic rsp_hs_qq;

    logic [mmio_tlp_pkg::data_w-1:0] rsp_data_first;
    logic [meta_w-1:0] meta_first;
    logic meta_not_empty;
    logic cpl_deq;

    logic [mmio_tlp_pkg::mmio_tag_w-1:0] meta_tag;
    logic [1:0] meta_vchan;
    logic [6:0] meta_lower_addr;
    logic [11:0] meta_byte_count;
    logic [15:0] meta_requester_id;
    logic [2:0] meta_tc;
    mmio_tlp_pkg::pcie_hdr_u cpl_hdr;

    logic [n_tags-1:0] tag_active;

    // Dropped TLPs drain at the same rate as accepted requests
    assign rx_ready = req_ready;

    assign req_valid = rx_valid && rx_sop && !rx_poison &&
                       mmio_tlp_pkg::is_mem_req(rx_hdr.mem_req.fmttype);

    assign req_tag = rx_hdr.mem_req.tag;
    assign req_addr = rx_hdr.mem_req.addr;
    assign req_byte_count = {rx_hdr.mem_req.length, 2'b00};
    assign req_is_write = mmio_tlp_pkg::is_mwr_req(rx_hdr.mem_req.fmttype);
    assign req_payload = rx_data;

    assign rd_accept = req_valid && req_ready &&
                       mmio_tlp_pkg::is_mrd_req(rx_hdr.mem_req.fmttype);
    assign rsp_hs = rsp_valid && rsp_ready;

    assign rd_idx = rx_hdr.mem_req.tag[tag_idx_w-1:0];
    assign rsp_idx = rsp_tag[tag_idx_w-1:0];

    assign rd_meta = {rx_hdr.mem_req.tag, rx_hdr.mem_req.vchan, rx_hdr.mem_req.addr[6:0],
                      req_byte_count, rx_hdr.mem_req.requester_id, rx_hdr.mem_req.tc};

    // Written at the accepting edge, so a one-cycle answer finds it in place
    meta_ram
    #(
        .n_entries(n_tags),
        .width(meta_w)
    )
    u_meta_ram
    (
        .clk(clk),
        .waddr(rd_idx),
        .wen(rd_accept),
        .wdata(rd_meta),
        .raddr(rsp_idx),
        .rdata(ram_rdata)
    );

    // RAM data is ready two edges after the response handshake
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_hs_q <= 1'b0;
            rsp_hs_qq <= 1'b0;
        end
        else
        begin
            rsp_hs_q <= rsp_hs;
            rsp_hs_qq <= rsp_hs_q;
        end
    end

    // Data arrives before its metadata, so the metadata FIFO
    // never holds more entries than the data FIFO
    fifo2
    #(
        .width(mmio_tlp_pkg::data_w)
    )
    u_rsp_data_fifo
    (
        .clk(clk),
        .reset_n(reset_n),
        .enq_data(rsp_payload),
        .enq_en(rsp_hs),
        .not_full(rsp_ready),
        .first(rsp_data_first),
        .deq_en(cpl_deq),
        .not_empty()
    );

    fifo2
    #(
        .width(meta_w)
    )
    u_rsp_meta_fifo
    (
        .clk(clk),
        .reset_n(reset_n),
        .enq_data(ram_rdata),
        .enq_en(rsp_hs_qq),
        .not_full(),
        .first(meta_first),
        .deq_en(cpl_deq),
        .not_empty(meta_not_empty)
    );

    assign {meta_tag, meta_vchan, meta_lower_addr, meta_byte_count,
            meta_requester_id, meta_tc} = meta_first;

    assign cpl_deq = meta_not_empty && (tx_ready || !tx_valid);

    always_comb
    begin
        cpl_hdr = '0;
        cpl_hdr.cpl.fmttype = mmio_tlp_pkg::fmttype_cpld;
        cpl_hdr.cpl.length = meta_byte_count[11:2];
        cpl_hdr.cpl.vchan = meta_vchan;
        cpl_hdr.cpl.tag = meta_tag;
        cpl_hdr.cpl.requester_id = meta_requester_id;
        cpl_hdr.cpl.tc = meta_tc;
        cpl_hdr.cpl.byte_count = meta_byte_count;
        cpl_hdr.cpl.lower_addr = meta_lower_addr;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tx_valid <= 1'b0;
        end
        else if (tx_ready || !tx_valid)
        begin
            tx_valid <= meta_not_empty;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cpl_deq)
        begin
            tx_hdr <= cpl_hdr;
            tx_data <= rsp_data_first;
            // Upper DW only for 8-byte reads
            tx_keep <= {(meta_byte_count[3] ? 4'hf : 4'h0), 4'hf};
        end
    end

    // Tags between read acceptance and response
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tag_active <= '0;
        end
        else
        begin
            if (rsp_hs)
            begin
                tag_active[rsp_idx] <= 1'b0;
            end
            if (rd_accept)
            begin
                tag_active[rd_idx] <= 1'b1;
            end
        end
    end

    a_rd_tag_free: assert property (@(posedge clk) disable iff (!reset_n)
        rd_accept |-> !tag_active[rd_idx])
        else $error("MMIO read with tag 0x%0h already active", rx_hdr.mem_req.tag);

    a_rsp_tag_active: assert property (@(posedge clk) disable iff (!reset_n)
        rsp_hs |-> tag_active[rsp_idx])
        else $error("MMIO response for inactive tag 0x%0h", rsp_tag);

    a_tx_hdr_stable: assert property (@(posedge clk) disable iff (!reset_n)
        tx_valid && !tx_ready |=> $stable(tx_hdr))
        else $error("Completion header changed while stalled");

endmodule

// File: source/fifo2.sv
/*
 * Two-entry FIFO
 * Registered not_full and not_empty flags, head entry on first
 */

`timescale 1ns/100ps

module fifo2
#(
    parameter int width = 64
)
(
    input  logic clk,
    input  logic reset_n,

    input  logic [width-1:0] enq_data,
    input  logic enq_en,
    output logic not_full,

    output logic [width-1:0] first,
    input  logic deq_en,
    output logic not_empty
);

    logic [width-1:0] mem [2];
    logic wr_ptr;
    logic rd_ptr;

    assign first = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            mem[wr_ptr] <= enq_data;
        end
    end

    // Occupancy is encoded in the two flags
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            not_empty <= 1'b0;
            not_full <= 1'b1;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= ~wr_ptr;
            end
            if (deq_en)
            begin
                rd_ptr <= ~rd_ptr;
            end

            if (enq_en && !deq_en)
            begin
                not_empty <= 1'b1;
                not_full <= !not_empty;
            end
            else if (deq_en && !enq_en)
            begin
                not_full <= 1'b1;
                not_empty <= !not_full;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        enq_en |-> not_full)
        else $error("Enqueue into full FIFO");

    a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
        deq_en |-> not_empty)
        else $error("Dequeue from empty FIFO");

endmodule

// File: source/meta_ram.sv
/*
 * Metadata RAM
 * One write port, one read port, registered read followed by
 * an output register stage
 */

`timescale 1ns/100ps

module meta_ram
#(
    parameter int n_entries = 64,
    parameter int width = 48
)
(
    input  logic clk,

    input  logic [$clog2(n_entries)-1:0] waddr,
    input  logic wen,
    input  logic [width-1:0] wdata,

    input  logic [$clog2(n_entries)-1:0] raddr,
    output logic [width-1:0] rdata
);

    logic [width-1:0] mem [n_entries];
    logic [width-1:0] rd_q;

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Read data shows up two edges after raddr is sampled
    always_ff @(posedge clk)
    begin
        rd_q <= mem[raddr];
        rdata <= rd_q;
    end

endmodule

// File: common/mmio_tlp_pkg.sv
/*
 * MMIO TLP definitions
 * Shared TLP header layout, format/type codes and decode helpers
 * for the host channel MMIO path
 */

package mmio_tlp_pkg;

    // One beat of payload, 8 bytes
    localparam int data_w = 64;

    localparam int mmio_tag_w = 8;

    // 3DW header encodings with 32-bit addressing
    localparam logic [7:0] fmttype_mrd = 8'h00;
    localparam logic [7:0] fmttype_mwr = 8'h40;
    localparam logic [7:0] fmttype_cpld = 8'h4a;

    // 128-bit TLP header, decoded either as a memory request or as a completion.
    // The leading fields sit at the same bit positions in both views.
    typedef union packed
    {
        struct packed
        {
            logic [7:0] fmttype;
            logic [9:0] length;
            logic [1:0] vchan;
            logic [7:0] tag;
            logic [15:0] requester_id;
            logic [2:0] tc;
            logic [31:0] addr;
            logic [48:0] pad;
        } mem_req;

        struct packed
        {
            logic [7:0] fmttype;
            logic [9:0] length;
            logic [1:0] vchan;
            logic [7:0] tag;
            logic [15:0] requester_id;
            logic [2:0] tc;
            logic [11:0] byte_count;
            logic [6:0] lower_addr;
            logic [61:0] pad;
        } cpl;
    } pcie_hdr_u;

    function automatic logic is_mrd_req(logic [7:0] fmttype);
        return fmttype == fmttype_mrd;
    endfunction

    function automatic logic is_mwr_req(logic [7:0] fmttype);
        return fmttype == fmttype_mwr;
    endfunction

    // Any memory request that the MMIO path serves
    function automatic logic is_mem_req(logic [7:0] fmttype);
        return is_mrd_req(fmttype) || is_mwr_req(fmttype);
    endfunction

endpackage
